// File: hw/soc_bus_pkg.sv
package soc_bus_pkg;

    // processor side
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // wishbone side is byte wide
    localparam int WB_DAT_W = 8;

    // byte counter inside the bridge, enough for a full word
    localparam int BYTE_CNT_W = 2;

    // index of the last byte for each access size
    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE_WORD = 2'd3; // fullword, 4 bytes
    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE_HALF = 2'd1; // halfword, 2 bytes
    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE_BYTE = 2'd0;

    // internal reset is held this many cycles after the button is released
    localparam int RESET_STRETCH = 16;
    localparam int RESET_CNT_W   = 5;

endpackage

// File: hw/soc_map_pkg.sv
package soc_map_pkg;

    localparam int IO_PAGE_W    = 24;
    localparam int REG_SEL_W    = 8;
    localparam int RAM_OFFSET_W = 12;   // 4 KiB of RAM

    // upper address bits of the io pages, everything else goes to RAM
    localparam logic [IO_PAGE_W-1:0] IO_PAGE_TIMER = 24'hFFFFFD;
    localparam logic [IO_PAGE_W-1:0] IO_PAGE_PRNG  = 24'hFFFFFE;

    // timer registers, compare value is little endian
    localparam logic [REG_SEL_W-1:0] TIMER_REG_CMP0 = 8'd0;
    localparam logic [REG_SEL_W-1:0] TIMER_REG_CMP1 = 8'd1;
    localparam logic [REG_SEL_W-1:0] TIMER_REG_CMP2 = 8'd2;
    localparam logic [REG_SEL_W-1:0] TIMER_REG_CMP3 = 8'd3;
    localparam logic [REG_SEL_W-1:0] TIMER_REG_CTRL = 8'd4; // bit 0 enable, bit 1 irq flag

    // prng state bytes, reading STATE3 advances the generator
    localparam logic [REG_SEL_W-1:0] PRNG_REG_STATE0 = 8'd0;
    localparam logic [REG_SEL_W-1:0] PRNG_REG_STATE1 = 8'd1;
    localparam logic [REG_SEL_W-1:0] PRNG_REG_STATE2 = 8'd2;
    localparam logic [REG_SEL_W-1:0] PRNG_REG_STATE3 = 8'd3;

    // one bus address, seen either as io page + register or as RAM offset
    typedef union packed {
        struct packed {
            logic [IO_PAGE_W-1:0] io_page;
            logic [REG_SEL_W-1:0] reg_sel;
        } io;
        struct packed {
            logic [IO_PAGE_W+REG_SEL_W-RAM_OFFSET_W-1:0] unused;
            logic [RAM_OFFSET_W-1:0]                     ram_offset;
        } ram;
    } bus_addr_u;

endpackage

// File: hw/wb8_if.sv
interface wb8_if;
    import soc_bus_pkg::*;

    logic [ADDR_W-1:0]   adr;
    logic [WB_DAT_W-1:0] dat_w;
    logic [WB_DAT_W-1:0] dat_r;
    logic                cyc;
    logic                stb;
    logic                we;
    logic                ack;    // one cycle after acceptance
    logic                stall;

    // bridge side
    modport master (
        output adr, dat_w, cyc, stb, we,
        input  dat_r, ack, stall
    );

    // decoder side
    modport slave (
        input  adr, dat_w, cyc, stb, we,
        output dat_r, ack, stall
    );

endinterface

// File: hw/wb8_bridge.sv
module wb8_bridge (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           strobe_i,
    input  logic                           write_i,
    input  logic                           halfword_i,
    input  logic                           fullword_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0] addr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0] data_i,
    output logic [soc_bus_pkg::DATA_W-1:0] data_o,
    output logic                           busy_o,
    output logic                           done_o,
    wb8_if.master                          wb
);
    import soc_bus_pkg::*;

    logic                  busy_q;     // access in progress
    logic                  stb_q;      // byte offered but not yet accepted
    logic                  write_q;
    logic [BYTE_CNT_W-1:0] cnt_q;      // byte being transferred
    logic [BYTE_CNT_W-1:0] last_q;
    logic [ADDR_W-1:0]     addr_q;
    logic [DATA_W-1:0]     wdata_q;    // shifts down one byte per ack
    logic [DATA_W-1:0]     rdata_q;
    logic [DATA_W-1:0]     rdata_next;
    logic                  start;
    logic                  byte_done;
    logic                  last_byte;

    assign start     = !busy_q && strobe_i;
    assign byte_done = busy_q && !stb_q && wb.ack;
    assign last_byte = (cnt_q == last_q);

    // current read byte dropped into its lane
    always_comb begin
        rdata_next = rdata_q;
        rdata_next[WB_DAT_W*cnt_q +: WB_DAT_W] = wb.dat_r;
    end

    // handshake control
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            stb_q  <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                stb_q  <= 1'b1;
            end else if (busy_q && stb_q) begin
                if (!wb.stall) begin
                    stb_q <= 1'b0;   // accepted, wait for ack
                end
            end else if (byte_done) begin
                if (last_byte) begin
                    busy_q <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    stb_q <= 1'b1;   // next byte
                end
            end
        end
    end

    // request and data path
    always_ff @(posedge clk) begin
        if (start) begin
            write_q <= write_i;
            addr_q  <= addr_i;
            wdata_q <= data_i;
            rdata_q <= '0;           // zero extension for short reads
            cnt_q   <= '0;
            if (fullword_i) begin
                last_q <= LAST_BYTE_WORD;
            end else if (halfword_i) begin
                last_q <= LAST_BYTE_HALF;
            end else begin
                last_q <= LAST_BYTE_BYTE;
            end
        end else if (byte_done) begin
            cnt_q   <= cnt_q + 1'b1;
            wdata_q <= wdata_q >> WB_DAT_W;
            rdata_q <= rdata_next;
            if (!write_q && last_byte) begin
                data_o <= rdata_next;  // held until the next read finishes
            end
        end
    end

    assign busy_o   = busy_q;
    assign wb.cyc   = busy_q;
    assign wb.stb   = stb_q;
    assign wb.we    = write_q;
    assign wb.adr   = addr_q + ADDR_W'(cnt_q);  // little endian, +0 first
    assign wb.dat_w = wdata_q[WB_DAT_W-1:0];

endmodule

// File: hw/wb8_decoder.sv
module wb8_decoder (
    wb8_if.slave                             bus,
    output logic                             ram_stb_o,
    input  logic [soc_bus_pkg::WB_DAT_W-1:0] ram_dat_i,
    input  logic                             ram_ack_i,
    input  logic                             ram_stall_i,
    output logic                             timer_stb_o,
    input  logic [soc_bus_pkg::WB_DAT_W-1:0] timer_dat_i,
    input  logic                             timer_ack_i,
    output logic                             prng_stb_o,
    input  logic [soc_bus_pkg::WB_DAT_W-1:0] prng_dat_i,
    input  logic                             prng_ack_i
);
    import soc_map_pkg::*;

    bus_addr_u adr;
    logic      stb;

    assign adr = bus.adr;
    assign stb = bus.cyc && bus.stb;   // no strobe outside a cycle

    // address stays put until ack, so the same arm returns the ack
    always_comb begin
        ram_stb_o   = 1'b0;
        timer_stb_o = 1'b0;
        prng_stb_o  = 1'b0;
        bus.stall   = 1'b0;   // only the RAM stalls

        case (adr.io.io_page)
            IO_PAGE_TIMER: begin
                bus.dat_r   = timer_dat_i;
                bus.ack     = timer_ack_i;
                timer_stb_o = stb;
            end

            IO_PAGE_PRNG: begin
                bus.dat_r  = prng_dat_i;
                bus.ack    = prng_ack_i;
                prng_stb_o = stb;
            end

            // anything else aliases into RAM
            default: begin
                bus.dat_r = ram_dat_i;
                bus.ack   = ram_ack_i;
                bus.stall = ram_stall_i;
                ram_stb_o = stb;
            end
        endcase
    end

endmodule

// File: hw/ram_wb8.sv
module ram_wb8 (
    input  logic                             clk,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  soc_map_pkg::bus_addr_u           adr_i,
    input  logic [soc_bus_pkg::WB_DAT_W-1:0] dat_i,
    output logic [soc_bus_pkg::WB_DAT_W-1:0] dat_o,
    output logic                             ack_o,
    output logic                             stall_o
);
    import soc_map_pkg::*;

    localparam int DEPTH = 1 << RAM_OFFSET_W;

    logic [soc_bus_pkg::WB_DAT_W-1:0] mem [DEPTH];
    logic                             accept;

    // nothing is taken during the recovery cycle
    assign accept = stb_i && !stall_o;

    always_ff @(posedge clk) begin
        ack_o   <= accept;
        stall_o <= accept;   // one recovery cycle after each access
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (we_i) begin
                mem[adr_i.ram.ram_offset] <= dat_i;
            end
            dat_o <= mem[adr_i.ram.ram_offset];  // old data on a write
        end
    end

endmodule

// File: hw/timer_wb8.sv
module timer_wb8 (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  soc_map_pkg::bus_addr_u           adr_i,
    input  logic [soc_bus_pkg::WB_DAT_W-1:0] dat_i,
    output logic [soc_bus_pkg::WB_DAT_W-1:0] dat_o,
    output logic                             ack_o,
    output logic                             irq_o
);
    import soc_bus_pkg::*;
    import soc_map_pkg::*;

    logic [DATA_W-1:0] count_q;
    logic [DATA_W-1:0] cmp_q;
    logic              enable_q;
    logic              flag_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_q  <= '0;
            cmp_q    <= '0;
            enable_q <= 1'b0;
            flag_q   <= 1'b0;
            ack_o    <= 1'b0;
        end else begin
            ack_o <= stb_i;   // never stalls
            if (enable_q) begin
                if (count_q == cmp_q) begin
                    count_q <= '0;
                    flag_q  <= 1'b1;
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end
            // a flag clear in the same cycle wins over a match
            if (stb_i && we_i) begin
                case (adr_i.io.reg_sel)
                    TIMER_REG_CMP0: cmp_q[7:0]   <= dat_i;
                    TIMER_REG_CMP1: cmp_q[15:8]  <= dat_i;
                    TIMER_REG_CMP2: cmp_q[23:16] <= dat_i;
                    TIMER_REG_CMP3: cmp_q[31:24] <= dat_i;
                    TIMER_REG_CTRL: begin
                        enable_q <= dat_i[0];
                        if (dat_i[1]) begin
                            flag_q <= 1'b0;   // write 1 to clear
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // read data, valid in the ack cycle
    always_ff @(posedge clk) begin
        if (stb_i) begin
            case (adr_i.io.reg_sel)
                TIMER_REG_CMP0: dat_o <= cmp_q[7:0];
                TIMER_REG_CMP1: dat_o <= cmp_q[15:8];
                TIMER_REG_CMP2: dat_o <= cmp_q[23:16];
                TIMER_REG_CMP3: dat_o <= cmp_q[31:24];
                TIMER_REG_CTRL: dat_o <= {{(WB_DAT_W-2){1'b0}}, flag_q, enable_q};
                default:        dat_o <= '0;
            endcase
        end
    end

    assign irq_o = flag_q;

endmodule

// File: hw/prng_wb8.sv
module prng_wb8 (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  soc_map_pkg::bus_addr_u           adr_i,
    input  logic [soc_bus_pkg::WB_DAT_W-1:0] dat_i,
    output logic [soc_bus_pkg::WB_DAT_W-1:0] dat_o,
    output logic                             ack_o
);
    import soc_bus_pkg::*;
    import soc_map_pkg::*;

    logic [DATA_W-1:0] state_q;

    // one xorshift32 step
    function automatic logic [DATA_W-1:0] xorshift32(input logic [DATA_W-1:0] x);
        logic [DATA_W-1:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= 32'd1;   // zero would lock the generator
            ack_o   <= 1'b0;
        end else begin
            ack_o <= stb_i;
            if (stb_i && we_i) begin
                case (adr_i.io.reg_sel)
                    PRNG_REG_STATE0: state_q[7:0]   <= dat_i;
                    PRNG_REG_STATE1: state_q[15:8]  <= dat_i;
                    PRNG_REG_STATE2: state_q[23:16] <= dat_i;
                    PRNG_REG_STATE3: state_q[31:24] <= dat_i;
                    default: ;
                endcase
            end else if (stb_i && adr_i.io.reg_sel == PRNG_REG_STATE3) begin
                state_q <= xorshift32(state_q);  // top byte read ends a word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stb_i) begin
            case (adr_i.io.reg_sel)
                PRNG_REG_STATE0: dat_o <= state_q[7:0];
                PRNG_REG_STATE1: dat_o <= state_q[15:8];
                PRNG_REG_STATE2: dat_o <= state_q[23:16];
                PRNG_REG_STATE3: dat_o <= state_q[31:24];  // value before the step
                default:         dat_o <= '0;
            endcase
        end
    end

endmodule

// File: hw/soc_top.sv
module soc_top (
    input  logic                           clk,
    input  logic                           reset_button,
    input  logic                           cpu_strobe_i,
    input  logic                           cpu_write_i,
    input  logic                           cpu_halfword_i,
    input  logic                           cpu_fullword_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0] cpu_addr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0] cpu_data_i,
    output logic [soc_bus_pkg::DATA_W-1:0] cpu_data_o,
    output logic                           cpu_busy_o,
    output logic                           cpu_done_o,
    output logic                           timer_irq_o
);
    import soc_bus_pkg::*;

    logic [RESET_CNT_W-1:0] reset_cnt_q;
    logic                   rst_q;        // stretched internal reset
    logic                   bridge_busy;

    logic                ram_stb;
    logic [WB_DAT_W-1:0] ram_dat;
    logic                ram_ack;
    logic                ram_stall;
    logic                timer_stb;
    logic [WB_DAT_W-1:0] timer_dat;
    logic                timer_ack;
    logic                prng_stb;
    logic [WB_DAT_W-1:0] prng_dat;
    logic                prng_ack;

    wb8_if wb ();

    // reloaded while the button is held, counts down after release
    always_ff @(posedge clk) begin
        if (!reset_button) begin
            reset_cnt_q <= RESET_CNT_W'(RESET_STRETCH - 1);
            rst_q       <= 1'b1;
        end else if (reset_cnt_q != '0) begin
            reset_cnt_q <= reset_cnt_q - 1'b1;
            rst_q       <= 1'b1;
        end else begin
            rst_q <= 1'b0;
        end
    end

    assign cpu_busy_o = bridge_busy || rst_q;  // cpu waits out the reset

    wb8_bridge bridge_i (
        .clk(clk), .rst_i(rst_q),
        .strobe_i(cpu_strobe_i), .write_i(cpu_write_i),
        .halfword_i(cpu_halfword_i), .fullword_i(cpu_fullword_i),
        .addr_i(cpu_addr_i), .data_i(cpu_data_i), .data_o(cpu_data_o),
        .busy_o(bridge_busy), .done_o(cpu_done_o), .wb(wb)
    );

    wb8_decoder decoder_i (
        .bus(wb),
        .ram_stb_o(ram_stb), .ram_dat_i(ram_dat),
        .ram_ack_i(ram_ack), .ram_stall_i(ram_stall),
        .timer_stb_o(timer_stb), .timer_dat_i(timer_dat), .timer_ack_i(timer_ack),
        .prng_stb_o(prng_stb), .prng_dat_i(prng_dat), .prng_ack_i(prng_ack)
    );

    ram_wb8 ram_i (
        .clk(clk), .stb_i(ram_stb), .we_i(wb.we), .adr_i(wb.adr), .dat_i(wb.dat_w),
        .dat_o(ram_dat), .ack_o(ram_ack), .stall_o(ram_stall)
    );

    timer_wb8 timer_i (
        .clk(clk), .rst_i(rst_q), .stb_i(timer_stb), .we_i(wb.we), .adr_i(wb.adr),
        .dat_i(wb.dat_w), .dat_o(timer_dat), .ack_o(timer_ack), .irq_o(timer_irq_o)
    );

    prng_wb8 prng_i (
        .clk(clk), .rst_i(rst_q), .stb_i(prng_stb), .we_i(wb.we), .adr_i(wb.adr),
        .dat_i(wb.dat_w), .dat_o(prng_dat), .ack_o(prng_ack)
    );

endmodule

// File: tests/clock_gen.sv
module clock_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk_o = 1'b0;

    always #10 clk_o = ~clk_o;   // 20 ns period

endmodule

// File: tests/soc_checker.sv
module soc_checker (
    input logic clk,
    input logic rst_i,
    input logic cpu_strobe_i,
    input logic cpu_busy_i,
    input logic cpu_done_i,
    input logic cyc_i,
    input logic stb_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;   // read by the testbench at the end

    no_strobe_while_busy: assert property (@(posedge clk) cpu_strobe_i |-> !cpu_busy_i)
        else begin
            fail_cnt++;
            $error("processor strobe while the bus is busy");
        end

    stb_within_cyc: assert property (@(posedge clk) disable iff (rst_i !== 1'b0)
        stb_i |-> cyc_i)
        else begin
            fail_cnt++;
            $error("wishbone stb high outside a cycle");
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (rst_i !== 1'b0)
        cpu_done_i |=> !cpu_done_i)
        else begin
            fail_cnt++;
            $error("done strobe longer than one cycle");
        end

    // bridge registers clear on the edge after rst_q rises
    quiet_in_reset: assert property (@(posedge clk) rst_i && $past(rst_i) |-> !cyc_i && !stb_i)
        else begin
            fail_cnt++;
            $error("wishbone cycle during internal reset");
        end

endmodule

bind soc_top soc_checker bus_check_i (
    .clk(clk), .rst_i(rst_q), .cpu_strobe_i(cpu_strobe_i), .cpu_busy_i(cpu_busy_o),
    .cpu_done_i(cpu_done_o), .cyc_i(wb.cyc), .stb_i(wb.stb)
);

// File: tests/soc_tb.sv
module soc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import soc_bus_pkg::*;
    import soc_map_pkg::*;

    localparam logic [DATA_W-1:0] SEED = 32'd71629;
    localparam int MAX_CYCLES      = 20000;  // whole run needs well under 1000 cycles
    localparam int MIN_WORD_CYCLES = 9;      // 4 bytes at 2 cycles each plus the strobe

    logic              clk;
    logic              reset_button;
    logic              cpu_strobe_i;
    logic              cpu_write_i;
    logic              cpu_halfword_i;
    logic              cpu_fullword_i;
    logic [ADDR_W-1:0] cpu_addr_i;
    logic [DATA_W-1:0] cpu_data_i;
    logic [DATA_W-1:0] cpu_data_o;
    logic              cpu_busy_o;
    logic              cpu_done_o;
    logic              timer_irq_o;

    logic [WB_DAT_W-1:0] ram_model [1 << RAM_OFFSET_W];
    logic [DATA_W-1:0]   rng_state = SEED;
    int                  errors = 0;
    int                  cycles_run = 0;

    clock_gen clk_gen_i (.clk_o(clk));

    soc_top dut_i (
        .clk(clk), .reset_button(reset_button),
        .cpu_strobe_i(cpu_strobe_i), .cpu_write_i(cpu_write_i),
        .cpu_halfword_i(cpu_halfword_i), .cpu_fullword_i(cpu_fullword_i),
        .cpu_addr_i(cpu_addr_i), .cpu_data_i(cpu_data_i), .cpu_data_o(cpu_data_o),
        .cpu_busy_o(cpu_busy_o), .cpu_done_o(cpu_done_o), .timer_irq_o(timer_irq_o)
    );

    function automatic logic [DATA_W-1:0] xorshift_step(input logic [DATA_W-1:0] x);
        logic [DATA_W-1:0] y;
        y = x;
        y ^= y << 13;
        y ^= y >> 17;
        y ^= y << 5;
        return y;
    endfunction

    function automatic logic [DATA_W-1:0] rand32();
        rng_state = xorshift_step(rng_state);
        return rng_state;
    endfunction

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // little endian bytes with the offset wrapping at 4 KiB
    task automatic model_write(input logic [ADDR_W-1:0] addr, input int nbytes,
                               input logic [DATA_W-1:0] data);
        logic [RAM_OFFSET_W-1:0] off;
        for (int i = 0; i < nbytes; i++) begin
            off = addr[RAM_OFFSET_W-1:0] + RAM_OFFSET_W'(i);
            ram_model[off] = data[WB_DAT_W*i +: WB_DAT_W];
        end
    endtask

    function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr,
                                                     input int nbytes);
        logic [DATA_W-1:0]       value;
        logic [RAM_OFFSET_W-1:0] off;
        value = '0;   // short reads are zero extended
        for (int i = 0; i < nbytes; i++) begin
            off = addr[RAM_OFFSET_W-1:0] + RAM_OFFSET_W'(i);
            value[WB_DAT_W*i +: WB_DAT_W] = ram_model[off];
        end
        return value;
    endfunction

    // one processor access with cycles counted from the strobe edge to the done edge
    task automatic bus_access(input logic write, input int nbytes,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output int cycles);
        int n;
        @(posedge clk);
        cpu_strobe_i   <= 1'b1;
        cpu_write_i    <= write;
        cpu_fullword_i <= (nbytes == 4);
        cpu_halfword_i <= (nbytes == 2);
        cpu_addr_i     <= addr;
        cpu_data_i     <= wdata;
        @(posedge clk);
        cpu_strobe_i <= 1'b0;
        n = 1;
        @(negedge clk);
        while (!cpu_done_o) begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end
        rdata  = cpu_data_o;
        cycles = n;
    endtask

    task automatic reset_release();
        int n;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag("cpu_busy_o", cpu_busy_o, 1'b1);   // button still held
        @(posedge clk);
        reset_button <= 1'b1;
        n = 0;
        @(negedge clk);
        while (cpu_busy_o && n < 4 * RESET_STRETCH) begin
            check_flag("cpu_done_o", cpu_done_o, 1'b0);
            check_flag("timer_irq_o", timer_irq_o, 1'b0);
            n++;
            @(negedge clk);
        end
        check_data("cpu_busy_o high cycles", n, RESET_STRETCH);
    endtask

    task automatic ram_readback();
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] rdata;
        int                nbytes;
        int                cycles;
        for (int i = 0; i < 12; i++) begin
            case (i % 3)
                0:       nbytes = 1;
                1:       nbytes = 2;
                default: nbytes = 4;
            endcase
            addr = rand32() & 32'h0000_0FFF;
            data = rand32();
            bus_access(1'b1, nbytes, addr, data, rdata, cycles);
            model_write(addr, nbytes, data);
            bus_access(1'b0, nbytes, addr, '0, rdata, cycles);
            check_data("cpu_data_o", rdata, model_read(addr, nbytes));
        end
    endtask

    task automatic default_alias();
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] rdata;
        int                cycles;
        addr = 32'h0003_4A7C;   // not an io page
        data = rand32();
        bus_access(1'b1, 4, addr, data, rdata, cycles);
        model_write(addr, 4, data);
        bus_access(1'b0, 4, addr & 32'h0000_0FFF, '0, rdata, cycles);
        check_data("cpu_data_o", rdata, data);
    endtask

    task automatic prng_sequence();
        logic [DATA_W-1:0] seed;
        logic [DATA_W-1:0] expected;
        logic [DATA_W-1:0] rdata;
        int                cycles;
        seed = rand32();
        bus_access(1'b1, 4, {IO_PAGE_PRNG, PRNG_REG_STATE0}, seed, rdata, cycles);
        expected = seed;
        for (int i = 0; i < 3; i++) begin
            bus_access(1'b0, 4, {IO_PAGE_PRNG, PRNG_REG_STATE0}, '0, rdata, cycles);
            check_data("cpu_data_o", rdata, expected);
            expected = xorshift_step(expected);   // top byte read steps the generator
        end
    endtask

    task automatic timer_interrupt();
        logic [DATA_W-1:0] rdata;
        int                cycles;
        int                n;
        bus_access(1'b1, 4, {IO_PAGE_TIMER, TIMER_REG_CMP0}, 32'd50, rdata, cycles);
        bus_access(1'b1, 1, {IO_PAGE_TIMER, TIMER_REG_CTRL}, 32'h1, rdata, cycles);
        n = 0;
        while (!timer_irq_o && n < 200) begin
            @(negedge clk);
            n++;
        end
        check_flag("timer_irq_o", timer_irq_o, 1'b1);
        if (n < 50 || n > 100) begin
            errors++;
            $display("timer interrupt came after %0d cycles, not within 50 to 100", n);
        end
        bus_access(1'b0, 1, {IO_PAGE_TIMER, TIMER_REG_CTRL}, '0, rdata, cycles);
        check_flag("timer ctrl flag", rdata[1], 1'b1);
        bus_access(1'b1, 1, {IO_PAGE_TIMER, TIMER_REG_CTRL}, 32'h2, rdata, cycles);
        check_flag("timer_irq_o", timer_irq_o, 1'b0);
        bus_access(1'b0, 4, {IO_PAGE_TIMER, TIMER_REG_CMP0}, '0, rdata, cycles);
        check_data("cpu_data_o", rdata, 32'd50);
    endtask

    task automatic back_to_back_reads();
        logic [ADDR_W-1:0] addrs [3];
        logic [DATA_W-1:0] rdata;
        int                cycles;
        for (int i = 0; i < 3; i++) begin
            addrs[i] = rand32() & 32'h0000_0FFC;
            bus_access(1'b1, 4, addrs[i], rand32(), rdata, cycles);
            model_write(addrs[i], 4, cpu_data_i);
        end
        for (int i = 0; i < 3; i++) begin
            bus_access(1'b0, 4, addrs[i], '0, rdata, cycles);
            check_data("cpu_data_o", rdata, model_read(addrs[i], 4));
            if (cycles < MIN_WORD_CYCLES) begin
                errors++;
                $display("word read took %0d cycles, fewer than %0d", cycles, MIN_WORD_CYCLES);
            end
        end
    endtask

    initial begin
        reset_button   = 1'b0;
        cpu_strobe_i   = 1'b0;
        cpu_write_i    = 1'b0;
        cpu_halfword_i = 1'b0;
        cpu_fullword_i = 1'b0;
        cpu_addr_i     = '0;
        cpu_data_i     = '0;
        reset_release();
        ram_readback();
        default_alias();
        prng_sequence();
        timer_interrupt();
        back_to_back_reads();
        $display("errors: %0d in checks, %0d in assertions",
                 errors, dut_i.bus_check_i.fail_cnt);
        if (errors == 0 && dut_i.bus_check_i.fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // hard stop in case a done strobe never comes
    initial begin
        while (cycles_run < MAX_CYCLES) begin
            @(posedge clk);
            cycles_run++;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", cycles_run);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: verilog.f
hw/soc_bus_pkg.sv
hw/soc_map_pkg.sv
hw/wb8_if.sv
hw/wb8_bridge.sv
hw/wb8_decoder.sv
hw/ram_wb8.sv
hw/timer_wb8.sv
hw/prng_wb8.sv
hw/soc_top.sv
tests/clock_gen.sv
tests/soc_checker.sv
tests/soc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
verilator --binary --assert --top-module soc_tb -f verilog.f -Mdir obj_dir \
    && ./obj_dir/Vsoc_tb | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
